/* verilog/dsi_pkg.sv */
package dsi_pkg;

	//--------------------------------------------------------------------
	// Pixel and lane types
	//--------------------------------------------------------------------
	typedef logic [23:0] rgb_t; // Red in [23:16], green in [15:8], blue in [7:0]
	typedef logic [1:0][23:0] pix_pair_t; // [0] even pixel, [1] odd pixel
	typedef logic [31:0] lane_word_t; // Byte k goes out on lane k

	localparam int NUM_LANES = 4; // HS data lanes

	typedef enum logic [5:0] {
		DT_VSYNC_START = 6'h01, // Short packet, start of frame
		DT_RGB888      = 6'h3E // Long packet, 24 bpp packed
	} dsi_dtype_e;

	localparam logic [15:0] CRC_INIT = 16'hFFFF; // Checksum seed per long packet

	// Bar order left to right
	localparam rgb_t BAR_COLORS [8] = '{
		24'hFF_FF_FF, // White
		24'hFF_FF_00, // Yellow
		24'h00_FF_FF, // Cyan
		24'h00_FF_00, // Green
		24'hFF_00_FF, // Magenta
		24'hFF_00_00, // Red
		24'h00_00_FF, // Blue
		24'h00_00_00 // Black
	};

	//--------------------------------------------------------------------
	// Header ECC and payload checksum
	//--------------------------------------------------------------------

	// Hamming parity over {wc_hi, wc_lo, data_id}, bit 0 is data_id[0]
	function automatic logic [7:0] dsi_ecc(input logic [23:0] hdr);
		logic [5:0] p;
		p[0] = ^(hdr & 24'hF12CB7);
		p[1] = ^(hdr & 24'hF2555B);
		p[2] = ^(hdr & 24'h749A6D);
		p[3] = ^(hdr & 24'hB8E38E);
		p[4] = ^(hdr & 24'hDF03F0);
		p[5] = ^(hdr & 24'hEFFC00);
		return {2'b00, p}; // Top two bits always zero
	endfunction

	// x^16+x^12+x^5+1, reflected form, bits shifted in LSB first
	function automatic logic [15:0] crc16_byte(input logic [15:0] crc, input logic [7:0] data);
		logic [15:0] c;
		c = crc;
		for (int i = 0; i < 8; i++) begin
			if (c[0] ^ data[i])
				c = (c >> 1) ^ 16'h8408;
			else
				c = c >> 1;
		end
		return c;
	endfunction

endpackage

/* verilog/panel_power_ctrl.sv */
module panel_power_ctrl #(
	parameter int RST_HOLD   = 32,
	parameter int PWM_PERIOD = 16,
	parameter int PWM_DUTY   = 6
) (
	input  logic I_clk,
	input  logic RST_n,
	input  logic frame_done, // First one turns the backlight on
	output logic run, // Pattern generator enable
	output logic lcd_led_en,
	output logic lcd_led_pwm
);

	localparam int HW = $clog2(RST_HOLD + 1);
	localparam int PW = $clog2(PWM_PERIOD + 1);

	logic [HW-1:0] hold_cnt; // Saturates at RST_HOLD
	logic [PW-1:0] pwm_cnt; // Position inside the PWM period

	always_ff @(posedge I_clk or negedge RST_n) begin
		if (!RST_n)
			hold_cnt <= '0;
		else if (!run)
			hold_cnt <= hold_cnt + 1'b1; // Stops once the hold expires
	end

	assign run = (hold_cnt == HW'(RST_HOLD));

	// Backlight stays on once a full frame has gone out
	always_ff @(posedge I_clk or negedge RST_n) begin
		if (!RST_n)
			lcd_led_en <= 1'b0;
		else if (frame_done)
			lcd_led_en <= 1'b1;
	end

	always_ff @(posedge I_clk or negedge RST_n) begin
		if (!RST_n)
			pwm_cnt <= PW'(PWM_PERIOD - 1); // Parked past the duty window while dark
		else if (lcd_led_en || frame_done) begin
			if (pwm_cnt == PW'(PWM_PERIOD - 1))
				pwm_cnt <= '0; // Period wrap, first wrap lines up with the enable
			else
				pwm_cnt <= pwm_cnt + 1'b1;
		end
	end

	assign lcd_led_pwm = (pwm_cnt < PW'(PWM_DUTY)); // High at period start

	a_pwm_needs_en: assert property (@(posedge I_clk) disable iff (!RST_n)
		lcd_led_pwm |-> lcd_led_en)
		else $error("backlight PWM active with backlight disabled");

endmodule

/* verilog/colorbar_gen.sv */
module colorbar_gen #(
	parameter int H_ACTIVE = 16,
	parameter int V_ACTIVE = 4
) (
	input  logic               I_clk,
	input  logic               RST_n,
	input  logic               run,
	input  logic               pix_ready,
	output logic               pix_valid,
	output dsi_pkg::pix_pair_t pix_data,
	output logic               pix_sof
);

	localparam int PAIRS = H_ACTIVE / 2; // Pixel pairs per line
	localparam int CW    = $clog2(PAIRS + 1);
	localparam int LW    = $clog2(V_ACTIVE + 1);

	logic [CW-1:0] col; // Pair index in the line
	logic [LW-1:0] line_cnt;
	logic          fire; // Pair accepted this cycle
	int            bar_even;
	int            bar_odd;

	assign pix_valid = run; // Source never runs dry
	assign fire      = pix_valid && pix_ready;
	assign pix_sof   = (col == '0) && (line_cnt == '0);

	// Raster scan, one pair per handshake
	always_ff @(posedge I_clk or negedge RST_n) begin
		if (!RST_n) begin
			col      <= '0;
			line_cnt <= '0;
		end else if (fire) begin
			if (col == CW'(PAIRS - 1)) begin
				col <= '0;
				if (line_cnt == LW'(V_ACTIVE - 1))
					line_cnt <= '0; // Next frame
				else
					line_cnt <= line_cnt + 1'b1;
			end else
				col <= col + 1'b1;
		end
	end

	// Bar index is x*8/H_ACTIVE
	always_comb begin
		bar_even    = (2 * int'(col) * 8) / H_ACTIVE;
		bar_odd     = ((2 * int'(col) + 1) * 8) / H_ACTIVE;
		pix_data[0] = dsi_pkg::BAR_COLORS[bar_even];
		pix_data[1] = dsi_pkg::BAR_COLORS[bar_odd];
	end

	a_pix_hold: assert property (@(posedge I_clk) disable iff (!RST_n)
		pix_valid && !pix_ready |=> pix_valid && $stable(pix_data) && $stable(pix_sof))
		else $error("pixel pair changed while stalled");

endmodule

/* verilog/pixel_byte_packer.sv */
module pixel_byte_packer (
	input  logic                I_clk,
	input  logic                RST_n,
	input  logic                pix_valid,
	input  dsi_pkg::pix_pair_t  pix_data,
	input  logic                pix_sof,
	input  logic                wr_ready,
	output logic                pix_ready,
	output logic                wr_valid,
	output dsi_pkg::lane_word_t wr_data,
	output logic                wr_sof
);

	logic [1:0]      phase; // 0,1,2 then back to 0
	logic [5:0][7:0] pb; // Pair as bytes in wire order
	logic [15:0]     carry; // Last two bytes of the phase 0 pair
	logic            out_free; // Output register can take a word
	logic            step; // Gearbox advances

	// Even pixel first, R G B within each pixel
	assign pb[0] = pix_data[0][23:16];
	assign pb[1] = pix_data[0][15:8];
	assign pb[2] = pix_data[0][7:0];
	assign pb[3] = pix_data[1][23:16];
	assign pb[4] = pix_data[1][15:8];
	assign pb[5] = pix_data[1][7:0];

	assign out_free  = !wr_valid || wr_ready;
	assign step      = out_free && pix_valid;
	assign pix_ready = out_free && (phase != 2'd1); // Phase 1 peeks, phase 2 takes

	//--------------------------------------------------------------------
	// Phase and handshake state
	//--------------------------------------------------------------------
	always_ff @(posedge I_clk or negedge RST_n) begin
		if (!RST_n) begin
			phase    <= 2'd0;
			wr_valid <= 1'b0;
			wr_sof   <= 1'b0;
		end else if (step) begin
			phase    <= (phase == 2'd2) ? 2'd0 : phase + 2'd1;
			wr_valid <= 1'b1;
			wr_sof   <= (phase == 2'd0) && pix_sof; // Frame starts on a phase 0 word
		end else if (wr_ready) begin
			wr_valid <= 1'b0; // Word drained, nothing new
		end
	end

	// Word assembly, lane 0 in the low byte
	always_ff @(posedge I_clk) begin
		if (step) begin
			case (phase)
				2'd0: begin
					wr_data <= {pb[3], pb[2], pb[1], pb[0]};
					carry   <= {pb[5], pb[4]};
				end
				2'd1: wr_data <= {pb[1], pb[0], carry}; // Carry plus head of held pair
				default: wr_data <= {pb[5], pb[4], pb[3], pb[2]};
			endcase
		end
	end

	a_phase_legal: assert property (@(posedge I_clk) disable iff (!RST_n)
		phase != 2'd3)
		else $error("gearbox phase out of range");

endmodule

/* verilog/line_fifo.sv */
module line_fifo #(
	parameter int FIFO_DEPTH = 32
) (
	input  logic                                I_clk,
	input  logic                                RST_n,
	input  logic                                wr_valid,
	input  dsi_pkg::lane_word_t                 wr_data,
	input  logic                                wr_sof,
	input  logic                                rd_en,
	output logic                                wr_ready,
	output dsi_pkg::lane_word_t                 rd_data,
	output logic                                rd_sof,
	output logic [$clog2(FIFO_DEPTH + 1) - 1:0] fill_count
);

	localparam int AW = $clog2(FIFO_DEPTH);
	localparam int CW = $clog2(FIFO_DEPTH + 1);
	localparam int DW = $bits(dsi_pkg::lane_word_t) + 1; // Word plus SOF flag

	logic [DW-1:0] mem [FIFO_DEPTH];
	logic [AW-1:0] wr_ptr;
	logic [AW-1:0] rd_ptr;
	logic          do_wr;

	assign wr_ready          = (fill_count != CW'(FIFO_DEPTH)); // Not full
	assign do_wr             = wr_valid && wr_ready;
	assign {rd_sof, rd_data} = mem[rd_ptr]; // Fall-through head

	always_ff @(posedge I_clk) begin
		if (do_wr)
			mem[wr_ptr] <= {wr_sof, wr_data};
	end

	//--------------------------------------------------------------------
	// Pointers and occupancy
	//--------------------------------------------------------------------
	always_ff @(posedge I_clk or negedge RST_n) begin
		if (!RST_n) begin
			wr_ptr     <= '0;
			rd_ptr     <= '0;
			fill_count <= '0;
		end else begin
			if (do_wr)
				wr_ptr <= (wr_ptr == AW'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (rd_en)
				rd_ptr <= (rd_ptr == AW'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			case ({do_wr, rd_en})
				2'b10: fill_count <= fill_count + 1'b1;
				2'b01: fill_count <= fill_count - 1'b1;
				default: fill_count <= fill_count; // Both or neither
			endcase
		end
	end

	a_no_underflow: assert property (@(posedge I_clk) disable iff (!RST_n)
		rd_en |-> fill_count != '0)
		else $error("read from empty line FIFO");

endmodule

/* verilog/dsi_packetizer.sv */
module dsi_packetizer #(
	parameter int H_ACTIVE   = 16,
	parameter int V_ACTIVE   = 4,
	parameter int FIFO_DEPTH = 32,
	parameter int LP_GAP     = 3
) (
	input  logic                                I_clk,
	input  logic                                RST_n,
	input  dsi_pkg::lane_word_t                 rd_data,
	input  logic                                rd_sof,
	input  logic [$clog2(FIFO_DEPTH + 1) - 1:0] fill_count,
	output logic                                rd_en,
	output logic                                hs_clk_en,
	output logic                                hs_data_en,
	output dsi_pkg::lane_word_t                 hs_lane_data,
	output logic                                frame_done
);

	localparam int WPL = H_ACTIVE * 3 / dsi_pkg::NUM_LANES; // Payload words per line
	localparam int PW  = $clog2(WPL + 1);
	localparam int GW  = $clog2(LP_GAP + 1);
	localparam int LW  = $clog2(V_ACTIVE + 1);

	//--------------------------------------------------------------------
	// Fixed packet words
	//--------------------------------------------------------------------
	localparam logic [15:0] WC     = 16'(H_ACTIVE * 3); // Payload bytes
	localparam logic [7:0]  DI_VSS = {2'b00, dsi_pkg::DT_VSYNC_START}; // Virtual channel 0
	localparam logic [7:0]  DI_RGB = {2'b00, dsi_pkg::DT_RGB888};
	localparam dsi_pkg::lane_word_t VSS_WORD =
		{dsi_pkg::dsi_ecc({16'h0000, DI_VSS}), 16'h0000, DI_VSS};
	localparam dsi_pkg::lane_word_t HDR_WORD =
		{dsi_pkg::dsi_ecc({WC, DI_RGB}), WC, DI_RGB};

	typedef enum logic [2:0] {IDLE, VSS, HEADER, PAYLOAD, FOOTER, GAP} state_e;

	state_e        state;
	logic [PW-1:0] word_cnt; // Payload word index
	logic [GW-1:0] gap_cnt;
	logic [LW-1:0] line_cnt; // Lines sent in this frame
	logic          vss_sent; // Header follows the current gap
	logic          line_ready; // Whole line waiting in the FIFO
	logic [15:0]   crc;
	logic [15:0]   crc_next;

	assign line_ready = (int'(fill_count) >= WPL);
	assign rd_en      = (state == PAYLOAD);
	assign hs_data_en = (state == VSS) || (state == HEADER) || (state == PAYLOAD) ||
		(state == FOOTER);

	always_comb begin
		case (state)
			VSS: hs_lane_data = VSS_WORD;
			HEADER: hs_lane_data = HDR_WORD;
			PAYLOAD: hs_lane_data = rd_data; // Straight from the FIFO head
			FOOTER: hs_lane_data = {16'h0000, crc}; // CRC low byte on lane 0
			default: hs_lane_data = '0;
		endcase
	end

	// Lane 0 byte is first on the wire
	always_comb begin
		crc_next = crc;
		for (int k = 0; k < dsi_pkg::NUM_LANES; k++)
			crc_next = dsi_pkg::crc16_byte(crc_next, rd_data[8*k +: 8]);
	end

	always_ff @(posedge I_clk) begin
		if (state == HEADER)
			crc <= dsi_pkg::CRC_INIT;
		else if (state == PAYLOAD)
			crc <= crc_next;
	end

	//--------------------------------------------------------------------
	// Packet sequencer
	//--------------------------------------------------------------------
	always_ff @(posedge I_clk or negedge RST_n) begin
		if (!RST_n) begin
			state      <= IDLE;
			word_cnt   <= '0;
			gap_cnt    <= '0;
			line_cnt   <= '0;
			vss_sent   <= 1'b0;
			hs_clk_en  <= 1'b0;
			frame_done <= 1'b0;
		end else begin
			frame_done <= 1'b0;
			case (state)
				IDLE: begin
					if (line_ready && !hs_clk_en)
						hs_clk_en <= 1'b1; // Clock lane leads the first burst
					else if (line_ready)
						state <= rd_sof ? VSS : HEADER;
				end
				VSS: begin
					vss_sent <= 1'b1;
					line_cnt <= '0;
					gap_cnt  <= '0;
					state    <= GAP;
				end
				HEADER: begin
					word_cnt <= '0;
					state    <= PAYLOAD;
				end
				PAYLOAD: begin
					word_cnt <= word_cnt + 1'b1;
					if (word_cnt == PW'(WPL - 1))
						state <= FOOTER;
				end
				FOOTER: begin
					gap_cnt <= '0;
					state   <= GAP;
					if (line_cnt == LW'(V_ACTIVE - 1)) begin
						line_cnt   <= '0;
						frame_done <= 1'b1; // Frame complete
					end else
						line_cnt <= line_cnt + 1'b1;
				end
				GAP: begin
					gap_cnt <= gap_cnt + 1'b1;
					if (gap_cnt == GW'(LP_GAP - 1)) begin
						vss_sent <= 1'b0;
						if (vss_sent)
							state <= HEADER; // Line behind the VSync packet
						else if (line_ready)
							state <= rd_sof ? VSS : HEADER; // Back to back
						else
							state <= IDLE;
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

	a_data_needs_clk: assert property (@(posedge I_clk) disable iff (!RST_n)
		hs_data_en |-> hs_clk_en)
		else $error("HS data burst without HS clock");

endmodule

/* verilog/dsi_video_top.sv */
module dsi_video_top #(
	parameter int H_ACTIVE   = 16, // Pixels per line, multiple of 4
	parameter int V_ACTIVE   = 4, // Lines per frame
	parameter int FIFO_DEPTH = 32, // Lane words, at least one line
	parameter int LP_GAP     = 3, // Idle cycles between bursts
	parameter int RST_HOLD   = 32, // Power-on hold in cycles
	parameter int PWM_PERIOD = 16,
	parameter int PWM_DUTY   = 6
) (
	input  logic                I_clk,
	input  logic                RST_n,
	output logic                hs_clk_en,
	output logic                hs_data_en,
	output dsi_pkg::lane_word_t hs_lane_data,
	output logic                lcd_led_en,
	output logic                lcd_led_pwm
);

	//--------------------------------------------------------------------
	// Pixel pipeline wires
	//--------------------------------------------------------------------
	logic                                 run; // Hold released
	logic                                 frame_done; // Last footer of a frame sent
	logic                                 pix_valid;
	logic                                 pix_ready;
	dsi_pkg::pix_pair_t                   pix_data;
	logic                                 pix_sof;
	logic                                 wr_valid;
	logic                                 wr_ready;
	dsi_pkg::lane_word_t                  wr_data;
	logic                                 wr_sof;
	logic                                 rd_en;
	dsi_pkg::lane_word_t                  rd_data;
	logic                                 rd_sof;
	logic [$clog2(FIFO_DEPTH + 1) - 1:0]  fill_count;

	panel_power_ctrl #(.RST_HOLD(RST_HOLD), .PWM_PERIOD(PWM_PERIOD), .PWM_DUTY(PWM_DUTY))
		panel_power_ctrl_inst (.*); // Reset hold and backlight

	colorbar_gen #(.H_ACTIVE(H_ACTIVE), .V_ACTIVE(V_ACTIVE))
		colorbar_gen_inst (.*); // Test pattern source

	pixel_byte_packer pixel_byte_packer_inst (.*); // Pairs to lane words

	line_fifo #(.FIFO_DEPTH(FIFO_DEPTH))
		line_fifo_inst (.*); // Line buffer

	dsi_packetizer #(
		.H_ACTIVE(H_ACTIVE),
		.V_ACTIVE(V_ACTIVE),
		.FIFO_DEPTH(FIFO_DEPTH),
		.LP_GAP(LP_GAP)
	) dsi_packetizer_inst (.*); // Packets onto four lanes

endmodule

/* verif/tb_dsi_ref.svh */
`ifndef TB_DSI_REF_SVH
`define TB_DSI_REF_SVH

	//----------------------------------------------------------------------
	// Reference model of the DSI stream
	//----------------------------------------------------------------------
	localparam logic [15:0] CRC_SEED = 16'hFFFF; // Checksum start value per line

	// Syndrome column per header bit D0..D23, bit j set when parity Pj covers it
	localparam logic [5:0] ECC_COLUMN [24] = '{
		6'h07, 6'h0B, 6'h0D, 6'h0E, 6'h13, 6'h15, 6'h16, 6'h19,
		6'h1A, 6'h1C, 6'h23, 6'h25, 6'h26, 6'h29, 6'h2A, 6'h2C,
		6'h31, 6'h32, 6'h34, 6'h38, 6'h1F, 6'h2F, 6'h37, 6'h3B
	};

	function automatic logic [7:0] header_ecc(input logic [23:0] hdr);
		logic [5:0] syn;
		syn = '0;
		for (int i = 0; i < 24; i++) begin
			if (hdr[i])
				syn ^= ECC_COLUMN[i]; // Sum of the columns of all set bits
		end
		return {2'b00, syn}; // P6 and P7 unused
	endfunction

	// One byte through the x^16+x^12+x^5+1 LFSR, LSB of the byte first
	function automatic logic [15:0] crc_step(input logic [15:0] crc, input logic [7:0] data);
		logic [15:0] c;
		logic        fb;
		c = crc;
		for (int i = 0; i < 8; i++) begin
			fb = c[0] ^ data[i];
			c  = {fb, c[15:12], c[11] ^ fb, c[10:5], c[4] ^ fb, c[3:1]}; // Reflected taps
		end
		return c;
	endfunction

	function automatic dsi_pkg::rgb_t bar_color(input int bar);
		logic [2:0] on; // Red, green, blue at full scale
		case (bar)
			0: on = 3'b111; // White
			1: on = 3'b110; // Yellow
			2: on = 3'b011; // Cyan
			3: on = 3'b010; // Green
			4: on = 3'b101; // Magenta
			5: on = 3'b100; // Red
			6: on = 3'b001; // Blue
			default: on = 3'b000; // Black
		endcase
		return {{8{on[2]}}, {8{on[1]}}, {8{on[0]}}};
	endfunction

	// Byte k of a line on the wire, pixel k/3, channel R G B
	function automatic logic [7:0] line_byte(input int k);
		dsi_pkg::rgb_t px;
		px = bar_color(((k / 3) * 8) / H_ACTIVE);
		return px[23 - 8 * (k % 3) -: 8];
	endfunction

	function automatic dsi_pkg::lane_word_t payload_word(input int w);
		dsi_pkg::lane_word_t wd;
		for (int k = 0; k < 4; k++)
			wd[8*k +: 8] = line_byte(4 * w + k); // Byte k on lane k
		return wd;
	endfunction

	function automatic logic [15:0] line_checksum();
		logic [15:0] c;
		c = CRC_SEED;
		for (int k = 0; k < H_ACTIVE * 3; k++)
			c = crc_step(c, line_byte(k));
		return c;
	endfunction

	//----------------------------------------------------------------------
	// Compare tasks
	//----------------------------------------------------------------------
	task automatic check_word(input string what, input dsi_pkg::lane_word_t exp,
		input dsi_pkg::lane_word_t act);
		check_count++;
		if (act !== exp) begin
			error_count++;
			$display("[FAIL] %s expected %h actual %h", what, exp, act);
		end
	endtask

	task automatic check_bit(input string what, input logic exp, input logic act);
		check_count++;
		if (act !== exp) begin
			error_count++;
			$display("[FAIL] %s expected %b actual %b", what, exp, act);
		end
	endtask

	task automatic compare_count(input string what, input int exp, input int act);
		check_count++;
		if (act != exp) begin
			error_count++;
			$display("[FAIL] %s expected %0d actual %0d", what, exp, act);
		end
	endtask

`endif

/* verif/tb_dsi_video_top.sv */
module tb_dsi_video_top;

	localparam int H_ACTIVE     = 16;
	localparam int V_ACTIVE     = 4;
	localparam int FIFO_DEPTH   = 32;
	localparam int LP_GAP       = 3;
	localparam int RST_HOLD     = 32;
	localparam int PWM_PERIOD   = 16;
	localparam int PWM_DUTY     = 6;
	localparam int CLK_PERIOD   = 4;
	localparam int RST_CYCLES   = 10;
	localparam int N_FRAMES     = 3; // Frames captured
	localparam int WPL          = H_ACTIVE * 3 / 4; // Payload words per line
	localparam int FRAME_CYCLES = (1 + LP_GAP) + V_ACTIVE * (WPL + 2 + LP_GAP);
	localparam int N_BURSTS     = N_FRAMES * (1 + V_ACTIVE); // VSync plus lines
	localparam int TAIL_CYCLES  = 2 * PWM_PERIOD + 4; // Extra PWM observation

	logic                I_clk;
	logic                RST_n;
	logic                hs_clk_en;
	logic                hs_data_en;
	dsi_pkg::lane_word_t hs_lane_data;
	logic                lcd_led_en;
	logic                lcd_led_pwm;

	int                  error_count;
	int                  check_count;
	int                  detail_frame; // Frame with payload compared byte by byte
	bit                  clk_hist[$]; // One entry per cycle after the hold
	bit                  led_hist[$];
	bit                  pwm_hist[$];
	int                  burst_start[$]; // Cycle of the first word
	int                  burst_len[$];
	int                  burst_base[$]; // Index into burst_words
	dsi_pkg::lane_word_t burst_words[$];

	`include "tb_dsi_ref.svh"

	dsi_video_top #(
		.H_ACTIVE(H_ACTIVE),
		.V_ACTIVE(V_ACTIVE),
		.FIFO_DEPTH(FIFO_DEPTH),
		.LP_GAP(LP_GAP),
		.RST_HOLD(RST_HOLD),
		.PWM_PERIOD(PWM_PERIOD),
		.PWM_DUTY(PWM_DUTY)
	) u_dut (
		.I_clk(I_clk),
		.RST_n(RST_n),
		.hs_clk_en(hs_clk_en),
		.hs_data_en(hs_data_en),
		.hs_lane_data(hs_lane_data),
		.lcd_led_en(lcd_led_en),
		.lcd_led_pwm(lcd_led_pwm)
	);

	always #(CLK_PERIOD / 2) I_clk = ~I_clk;

	// Twice the hold plus three frames of bursts and gaps
	initial begin
		#((RST_CYCLES + RST_HOLD + N_FRAMES * FRAME_CYCLES) * 2 * CLK_PERIOD);
		$display("Watchdog expired before the packet stream was complete");
		$display("ERRORS FOUND");
		$finish;
	end

	task automatic note_error(input string msg);
		error_count++;
		$display("%s", msg);
	endtask

	task automatic report_test(input string name, input int e0);
		$display("%s: %s (%0d mismatches)", name, (error_count == e0) ? "pass" : "fail",
			error_count - e0);
	endtask

	//----------------------------------------------------------------------
	// Stream capture, sampled on the falling edge
	//----------------------------------------------------------------------
	task automatic record_stream();
		int cyc;
		int tail;
		bit prev;
		cyc  = 0;
		tail = 0;
		prev = 1'b0;
		while (burst_len.size() < N_BURSTS || tail < TAIL_CYCLES) begin
			@(negedge I_clk);
			clk_hist.push_back(hs_clk_en);
			led_hist.push_back(lcd_led_en);
			pwm_hist.push_back(lcd_led_pwm);
			if (hs_data_en) begin
				if (!prev) begin
					burst_start.push_back(cyc); // New burst
					burst_base.push_back(burst_words.size());
				end
				burst_words.push_back(hs_lane_data);
			end else if (prev)
				burst_len.push_back(cyc - burst_start[$]); // Burst just ended
			if (burst_len.size() >= N_BURSTS)
				tail++;
			prev = hs_data_en;
			cyc++;
		end
	endtask

	task automatic startup_hold();
		int e0;
		int s;
		e0 = error_count;
		for (int k = 0; k < RST_HOLD; k++) begin
			@(negedge I_clk);
			check_bit("startup_hold hs_clk_en", 1'b0, hs_clk_en);
			check_bit("startup_hold hs_data_en", 1'b0, hs_data_en);
			check_bit("startup_hold lcd_led_en", 1'b0, lcd_led_en);
			check_bit("startup_hold lcd_led_pwm", 1'b0, lcd_led_pwm);
		end
		record_stream();
		s = burst_start[0];
		if (s < 2) begin
			note_error("startup_hold: first burst started with no HS clock lead cycle");
		end else begin
			for (int t = 0; t < clk_hist.size(); t++)
				check_bit($sformatf("startup_hold hs_clk_en cycle %0d", t), t >= s - 1,
					clk_hist[t]); // Rises one cycle ahead, then stays
		end
		report_test("startup_hold", e0);
	endtask

	task automatic frame_sync_packets();
		int e0;
		int b;
		logic [7:0] di;
		e0 = error_count;
		di = {2'b00, dsi_pkg::DT_VSYNC_START}; // Virtual channel 0
		for (int f = 0; f < N_FRAMES; f++) begin
			b = f * (1 + V_ACTIVE);
			compare_count($sformatf("frame_sync_packets length f%0d", f), 1, burst_len[b]);
			check_word($sformatf("frame_sync_packets word f%0d", f),
				{header_ecc({16'h0000, di}), 16'h0000, di}, burst_words[burst_base[b]]);
		end
		report_test("frame_sync_packets", e0);
	endtask

	task automatic line_packets();
		int e0;
		int b;
		int base;
		logic [7:0] di;
		logic [15:0] wc;
		e0 = error_count;
		di = {2'b00, dsi_pkg::DT_RGB888};
		wc = 16'(H_ACTIVE * 3); // Payload bytes
		for (int f = 0; f < N_FRAMES; f++) begin
			for (int l = 0; l < V_ACTIVE; l++) begin
				b = f * (1 + V_ACTIVE) + 1 + l;
				compare_count($sformatf("line_packets length f%0d l%0d", f, l), WPL + 2,
					burst_len[b]);
				if (burst_len[b] == WPL + 2) begin
					base = burst_base[b];
					check_word($sformatf("line_packets header f%0d l%0d", f, l),
						{header_ecc({wc, di}), wc, di}, burst_words[base]);
					if (f == detail_frame) begin
						for (int w = 0; w < WPL; w++)
							check_word($sformatf("line_packets payload f%0d l%0d w%0d", f, l, w),
								payload_word(w), burst_words[base + 1 + w]);
					end
				end
			end
		end
		report_test("line_packets", e0);
	endtask

	task automatic footer_checksums();
		int e0;
		int b;
		logic [15:0] crc;
		e0 = error_count;
		crc = line_checksum(); // Every line carries the same bars
		for (int f = 0; f < N_FRAMES; f++) begin
			for (int l = 0; l < V_ACTIVE; l++) begin
				b = f * (1 + V_ACTIVE) + 1 + l;
				if (burst_len[b] == WPL + 2)
					check_word($sformatf("footer_checksums f%0d l%0d", f, l), {16'h0000, crc},
						burst_words[burst_base[b] + WPL + 1]);
				else
					note_error($sformatf("footer_checksums: line f%0d l%0d has no footer", f, l));
			end
		end
		report_test("footer_checksums", e0);
	endtask

	task automatic packet_gaps();
		int e0;
		int lines;
		e0 = error_count;
		lines = 0;
		for (int b = 0; b < N_BURSTS; b++) begin
			if (b > 0)
				compare_count($sformatf("packet_gaps gap before burst %0d", b), LP_GAP,
					burst_start[b] - burst_start[b - 1] - burst_len[b - 1]);
			if (burst_len[b] == 1) begin
				if (b > 0)
					compare_count("packet_gaps lines per frame", V_ACTIVE, lines);
				lines = 0; // Short packet opens a frame
			end else
				lines++;
		end
		compare_count("packet_gaps lines in last frame", V_ACTIVE, lines);
		report_test("packet_gaps", e0);
	endtask

	task automatic backlight_pwm();
		int e0;
		int on_cyc;
		int full_end;
		logic exp_pwm;
		e0 = error_count;
		on_cyc = burst_start[V_ACTIVE] + burst_len[V_ACTIVE] + 1; // Footer, frame_done, enable
		full_end = on_cyc + ((led_hist.size() - on_cyc) / PWM_PERIOD) * PWM_PERIOD;
		for (int t = 0; t < led_hist.size(); t++) begin
			check_bit($sformatf("backlight_pwm enable cycle %0d", t), t >= on_cyc, led_hist[t]);
			if (t < full_end) begin
				exp_pwm = (t >= on_cyc) && (((t - on_cyc) % PWM_PERIOD) < PWM_DUTY);
				check_bit($sformatf("backlight_pwm level cycle %0d", t), exp_pwm, pwm_hist[t]);
			end
		end
		report_test("backlight_pwm", e0);
	endtask

	//----------------------------------------------------------------------
	// Main sequence
	//----------------------------------------------------------------------
	initial begin
		I_clk        = 1'b0;
		RST_n        = 1'b0;
		error_count  = 0;
		check_count  = 0;
		detail_frame = $urandom(32'hbac3_5894); // Seeds the generator
		detail_frame = int'($urandom % N_FRAMES);
		repeat (RST_CYCLES) @(negedge I_clk);
		RST_n = 1'b1;
		startup_hold();
		frame_sync_packets();
		line_packets();
		footer_checksums();
		packet_gaps();
		backlight_pwm();
		$display("Totals: %0d checks, %0d errors", check_count, error_count);
		if (error_count == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

endmodule

/* dsi_video_top.f */
verilog/dsi_pkg.sv
verilog/panel_power_ctrl.sv
verilog/colorbar_gen.sv
verilog/pixel_byte_packer.sv
verilog/line_fifo.sv
verilog/dsi_packetizer.sv
verilog/dsi_video_top.sv
+incdir+verif
verif/tb_dsi_video_top.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the DSI video testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_dsi_video_top \
	--Mdir obj_dir \
	-f dsi_video_top.f
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

out=$(./obj_dir/Vtb_dsi_video_top)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if echo "$out" | grep -qx "NO ERRORS"; then
	exit 0
fi
exit 1
